//--- src.f
+incdir+tests
logic/board_pkg.sv
logic/reset_sequencer.sv
logic/jamma_joy_sampler.sv
logic/ps2_key_scanner.sv
logic/reboot_requester.sv
logic/board_shell.sv
tests/board_shell_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the board shell testbench with verilator, run it, judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing -Wno-fatal --top-module board_shell_tb \
  -f src.f -o board_shell_sim > build.log 2>&1 \
  && ./obj_dir/board_shell_sim > sim.log 2>&1 \
  || { echo "build or run error"; cat build.log sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "Simulation PASSED" sim.log && echo "result: pass" && exit 0 \
  || { echo "result: fail"; exit 1; }

//--- tests/board_cases.txt
// one case per word, two hex digits each: kind arg0 arg1 exp0 exp1
// 01 reset(hold bits) 02 jamma(jjoy joystick a b) 03 lfsr jamma(count) 04 key(code brk flags)
// 05 bad frame(code 1=parity 2=stall flags) 06 jtest 07 reboot 08 service gap 09 mirror
0100000800 // reset release, 2**8 cycles
02A50F85A5 // a takes local port bits
02FF00C0FF // local port all pressed
025A33525A
0310000000 // 16 lfsr patterns
0476000400 // esc make
0476010000 // esc break
0600000100 // jtest low
0601000000 // jtest high
0406000200 // f2 make
0406010200 // f2 break, no change
0483000300 // f7 make
0483010300 // f7 break, no change
0506010300 // f2 with bad parity
0406000100 // f2 good frame
0583020100 // f7 stalled mid-frame
0483000000 // f7 good frame
0700070100 // f12 make, one pulse
0701640100 // service low 100 cycles
0810000100 // gap of 16, no rearm
0811000200 // gap of 17, rearmed
0920000000 // 32 lfsr mirror patterns
0000000000 // end

//--- tests/ps2_drive_tasks.svh
`ifndef PS2_DRIVE_TASKS_SVH
`define PS2_DRIVE_TASKS_SVH

////////////////////////////////////////
// ps/2 device side, bit-banged on pclk
////////////////////////////////////////
localparam int ps2_half_cycles = 8;  // half a ps/2 clock period in pclk cycles

task automatic ps2_half_wait();
  repeat (ps2_half_cycles) @(posedge pclk);
  #1;
endtask

// data changes while the clock is high, host samples on the fall
task automatic ps2_bit(input logic value);
  ps2_data = value;
  ps2_half_wait();
  ps2_clk = 1'b0;
  ps2_half_wait();
  ps2_clk = 1'b1;
endtask

// start, 8 data bits lsb first, odd parity, stop
task automatic ps2_send_frame(input logic [7:0] code, input logic bad_parity);
  int i;
  ps2_bit(1'b0);
  for (i = 0; i < 8; i++) begin
    ps2_bit(code[i]);
  end
  ps2_bit(~^code ^ bad_parity);  // flipped on request
  ps2_bit(1'b1);
  ps2_half_wait();                // bus idle between frames
  ps2_half_wait();
endtask

// start plus a few data bits, then the device goes silent
task automatic ps2_send_partial(input logic [7:0] code, input int nbits);
  int i;
  ps2_bit(1'b0);
  for (i = 0; i < nbits; i++) begin
    ps2_bit(code[i]);
  end
  ps2_data = 1'b1;
endtask

task automatic ps2_send_key(input logic [7:0] code, input logic release_key);
  if (release_key) begin
    ps2_send_frame(8'hf0, 1'b0);  // break prefix first
  end
  ps2_send_frame(code, 1'b0);
endtask

`endif

//--- tests/board_shell_tb.sv
`timescale 1ns/10ps

module board_shell_tb;

  localparam int max_cases = 64;

  logic                                pclk = 1'b0;
  logic                                pll_lckd;
  board_pkg::core_video_t              core_video;
  logic                                core_audio_l;
  logic                                core_audio_r;
  logic [board_pkg::joy_port_bits-1:0] joystick;
  board_pkg::joy_t                     jjoy;
  logic                                jtest;
  logic                                jservice;
  logic                                ps2_clk;
  logic                                ps2_data;
  board_pkg::core_video_t              vga_video;
  board_pkg::jamma_video_t             jamma_video;
  logic                                audio_l;
  logic                                audio_r;
  logic                                jaudio;
  logic                                jselect;
  board_pkg::joy_t                     joystick_a;
  board_pkg::joy_t                     joystick_b;
  logic                                core_reset;
  logic                                core_reset_key;
  logic                                ena_12;
  logic                                ena_6;
  logic                                reboot;
  logic                                led;
  logic                                scanlines;

  logic [39:0] cases [0:max_cases-1];  // kind, arg0, arg1, exp0, exp1
  int          errors = 0;
  int          reboot_pulses = 0;       // running count of reboot strobes
  logic [15:0] lfsr_state;

  board_shell #(
    .reset_hold_bits (8),
    .joy_type        (1)
  ) i_board_shell (.*);

  always #4 pclk = ~pclk;  // 8 ns period

  always @(negedge pclk) begin
    if (reboot === 1'b1) reboot_pulses++;  // strobes are one cycle wide
  end

  `include "ps2_drive_tasks.svh"

  ////////////////////////////////////////
  // reporting and random patterns
  ////////////////////////////////////////
  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
    $display("Fail at %0t ns: %s is %0h, expected %0h", $time, name, got, expected);
    errors++;
  endtask

  task automatic report_problem(input string what);
    $display("Error at %0t ns: %s", $time, what);
    errors++;
  endtask

  // galois lfsr, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] galois_step(input logic [15:0] s);
    logic [15:0] n;
    n = s >> 1;
    if (s[0]) n = n ^ 16'hb400;
    return n;
  endfunction

  task automatic draw_bits(input int nbits, output logic [15:0] value);
    int i;
    value = '0;
    for (i = 0; i < nbits; i++) begin
      value[i]   = lfsr_state[0];  // one step per bit
      lfsr_state = galois_step(lfsr_state);
    end
  endtask

  ////////////////////////////////////////
  // case runners
  ////////////////////////////////////////
  task automatic run_reset_case(input int hold_bits);
    int cycles;
    int expected;
    expected = 1 << hold_bits;
    @(posedge pclk);
    #1;
    pll_lckd = 1'b0;
    repeat (8) @(posedge pclk);
    #1;
    if (core_reset !== 1'b1) report_mismatch("core_reset", core_reset, 1);
    if (ena_12 !== 1'b0) report_mismatch("ena_12", ena_12, 0);
    if (ena_6 !== 1'b0) report_mismatch("ena_6", ena_6, 0);
    pll_lckd = 1'b1;
    cycles   = 0;
    while (core_reset === 1'b1 && cycles < 4 * expected) begin
      @(posedge pclk);
      cycles++;
      @(negedge pclk);
      if (ena_12 !== cycles[0]) report_mismatch("ena_12", ena_12, cycles[0]);
      if (ena_6 !== ((cycles % 4) == 1)) report_mismatch("ena_6", ena_6, (cycles % 4) == 1);
    end
    if (core_reset === 1'b1) report_problem("core_reset was never released");
    else if (cycles != expected) report_mismatch("core_reset release cycle", cycles, expected);
  endtask

  task automatic run_jamma_case(input logic [7:0] jjoy_v, input logic [5:0] joy_v,
                                input logic [7:0] exp_a, input logic [7:0] exp_b);
    logic prev_sel;
    int   i;
    @(posedge pclk);
    #1;
    jjoy     = jjoy_v;
    joystick = joy_v;
    prev_sel = jselect;
    for (i = 0; i < 4; i++) begin  // held 4 cycles
      @(posedge pclk);
      @(negedge pclk);
      if (jselect === prev_sel) report_mismatch("jselect", jselect, ~prev_sel);
      prev_sel = jselect;
    end
    if (joystick_a !== exp_a) report_mismatch("joystick_a", joystick_a, exp_a);
    if (joystick_b !== exp_b) report_mismatch("joystick_b", joystick_b, exp_b);
  endtask

  // flags are rk/sl/led, polled until they settle
  task automatic wait_for_flags(input logic [2:0] expected);
    logic [2:0] seen;
    int         cycles;
    cycles = 0;
    seen   = {core_reset_key, scanlines, led};
    while (seen !== expected && cycles < 64) begin
      @(negedge pclk);
      cycles++;
      seen = {core_reset_key, scanlines, led};
    end
    if (seen !== expected) report_mismatch("core_reset_key/scanlines/led", seen, expected);
  endtask

  task automatic run_reboot_case(input logic [7:0] kind, input logic [7:0] arg0,
                                 input logic [7:0] arg1, input int expected);
    int start;
    int cycles;
    @(posedge pclk);
    #1;
    start = reboot_pulses;
    if (kind == 8'h08) begin       // hold, gap of arg0 cycles, hold again
      jservice = 1'b0;
      repeat (30) @(posedge pclk);
      #1;
      jservice = 1'b1;
      repeat (arg0) @(posedge pclk);
      #1;
      jservice = 1'b0;
      repeat (30) @(posedge pclk);
      #1;
      jservice = 1'b1;
    end else if (arg0 == 8'h00) begin
      ps2_send_key(arg1, 1'b0);    // keyboard master key
    end else begin
      jservice = 1'b0;
      repeat (arg1) @(posedge pclk);
      #1;
      jservice = 1'b1;
    end
    cycles = 0;
    while ((reboot_pulses - start) < expected && cycles < 200) begin
      @(negedge pclk);
      cycles++;
    end
    if ((reboot_pulses - start) < expected) report_problem("reboot pulse never arrived");
    repeat (40) @(negedge pclk);   // room for a stray second pulse
    if (reboot_pulses - start != expected)
      report_mismatch("reboot pulse count", reboot_pulses - start, expected);
  endtask

  task automatic run_mirror_case(input int count);
    board_pkg::core_video_t  cv;
    board_pkg::jamma_video_t exp_jv;
    logic [15:0]             r;
    int                      i;
    for (i = 0; i < count; i++) begin
      @(posedge pclk);
      #1;
      draw_bits(11, r);
      cv = r[10:0];
      draw_bits(2, r);
      core_video   = cv;
      core_audio_l = r[0];
      core_audio_r = r[1];
      exp_jv.red   = cv.red * 4'd2;    // colour shifted up one, lsb low
      exp_jv.green = cv.green * 4'd2;
      exp_jv.blue  = cv.blue * 4'd2;
      exp_jv.hsync = cv.hsync;
      exp_jv.vsync = cv.vsync;
      @(negedge pclk);
      if (vga_video !== cv) report_mismatch("vga_video", vga_video, cv);
      if (jamma_video !== exp_jv) report_mismatch("jamma_video", jamma_video, exp_jv);
      if (jaudio !== r[0]) report_mismatch("jaudio", jaudio, r[0]);
      if (audio_l !== r[0]) report_mismatch("audio_l", audio_l, r[0]);
      if (audio_r !== r[1]) report_mismatch("audio_r", audio_r, r[1]);
    end
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////
  initial begin
    logic [39:0] entry;
    logic [15:0] r;
    logic [15:0] q;
    int          idx;
    int          i;
    int          err_before;
    int          failed_tests;
    pll_lckd     = 1'b0;
    core_video   = '0;
    core_audio_l = 1'b0;
    core_audio_r = 1'b0;
    joystick     = '1;     // nothing pressed
    jjoy         = '1;
    jtest        = 1'b1;
    jservice     = 1'b1;
    ps2_clk      = 1'b1;   // bus idle
    ps2_data     = 1'b1;
    lfsr_state   = 16'd94;
    failed_tests = 0;
    $readmemh("tests/board_cases.txt", cases);
    idx = 0;
    while (idx < max_cases && !$isunknown(cases[idx]) && cases[idx][39:32] != 8'h00) begin
      entry      = cases[idx];
      err_before = errors;
      case (entry[39:32])
        8'h01: run_reset_case(entry[15:8]);
        8'h02: run_jamma_case(entry[31:24], entry[21:16], entry[15:8], entry[7:0]);
        8'h03: begin
          for (i = 0; i < entry[31:24]; i++) begin
            draw_bits(8, r);
            draw_bits(6, q);
            // upper two buttons come from the cabinet alone
            run_jamma_case(r[7:0], q[5:0], {r[7:6], r[5:0] & q[5:0]}, r[7:0]);
          end
        end
        8'h04: begin
          @(posedge pclk);
          #1;
          ps2_send_key(entry[31:24], entry[16]);
          wait_for_flags(entry[10:8]);
        end
        8'h05: begin
          @(posedge pclk);
          #1;
          if (entry[23:16] == 8'h01) begin
            ps2_send_frame(entry[31:24], 1'b1);
          end else begin
            ps2_send_partial(entry[31:24], 4);
            repeat (board_pkg::ps2_timeout_cycles + 200) @(posedge pclk);  // past the stall limit
            #1;
          end
          wait_for_flags(entry[10:8]);
        end
        8'h06: begin
          @(posedge pclk);
          #1;
          jtest = entry[24];
          @(negedge pclk);
          if (core_reset_key !== entry[8])
            report_mismatch("core_reset_key", core_reset_key, entry[8]);
        end
        8'h07, 8'h08: run_reboot_case(entry[39:32], entry[31:24], entry[23:16], entry[15:8]);
        8'h09: run_mirror_case(entry[31:24]);
        default: report_problem($sformatf("unknown case kind %0h", entry[39:32]));
      endcase
      if (errors != err_before) failed_tests++;
      $display("test %0d kind %02h: %s", idx, entry[39:32],
               (errors == err_before) ? "ok" : "mismatch");
      idx++;
    end
    if (idx == 0) report_problem("no test cases were read");
    $display("tests %0d, failed %0d, errors %0d", idx, failed_tests, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- logic/board_shell.sv
`timescale 1ns/10ps

module board_shell #(
  parameter int reset_hold_bits = 8,  // 256 cycles of core reset
  parameter int joy_type        = 1   // jamma cabinet
) (
  input  logic                                 pclk,
  input  logic                                 pll_lckd,
  input  board_pkg::core_video_t               core_video,
  input  logic                                 core_audio_l,
  input  logic                                 core_audio_r,
  input  logic [board_pkg::joy_port_bits-1:0] joystick,
  input  board_pkg::joy_t                      jjoy,
  input  logic                                 jtest,
  input  logic                                 jservice,
  input  logic                                 ps2_clk,
  input  logic                                 ps2_data,
  output board_pkg::core_video_t               vga_video,
  output board_pkg::jamma_video_t              jamma_video,
  output logic                                 audio_l,
  output logic                                 audio_r,
  output logic                                 jaudio,
  output logic                                 jselect,
  output board_pkg::joy_t                      joystick_a,
  output board_pkg::joy_t                      joystick_b,
  output logic                                 core_reset,
  output logic                                 core_reset_key,
  output logic                                 ena_12,
  output logic                                 ena_6,
  output logic                                 reboot,
  output logic                                 led,
  output logic                                 scanlines
);

  board_pkg::key_flags_t key_flags;
  logic                  reset_hw;  // soft reset from keyboard or test switch

  ////////////////////////////////////////
  // clocking and reset
  ////////////////////////////////////////
  reset_sequencer #(
    .reset_hold_bits (reset_hold_bits)
  ) i_reset_sequencer (
    .pclk       (pclk),
    .pll_lckd   (pll_lckd),
    .core_reset (core_reset),
    .ena_12     (ena_12),
    .ena_6      (ena_6)
  );

  ////////////////////////////////////////
  // controls
  ////////////////////////////////////////
  jamma_joy_sampler #(
    .joy_type (joy_type)
  ) i_jamma_joy_sampler (
    .pclk       (pclk),
    .pll_lckd   (pll_lckd),
    .joystick   (joystick),
    .jjoy       (jjoy),
    .jselect    (jselect),
    .joystick_a (joystick_a),
    .joystick_b (joystick_b)
  );

  ps2_key_scanner i_ps2_key_scanner (
    .pclk      (pclk),
    .pll_lckd  (pll_lckd),
    .ps2_clk   (ps2_clk),
    .ps2_data  (ps2_data),
    .key_flags (key_flags)
  );

  assign reset_hw       = key_flags.reset_key | ~jtest;  // jtest active low
  assign core_reset_key = reset_hw;
  assign led            = key_flags.led_on;
  assign scanlines      = key_flags.scanlines;

  reboot_requester i_reboot_requester (
    .pclk         (pclk),
    .pll_lckd     (pll_lckd),
    .master_reset (key_flags.master_reset),
    .service      (jservice),
    .reboot       (reboot)
  );

  ////////////////////////////////////////
  // video and audio mirroring
  ////////////////////////////////////////
  assign vga_video = core_video;

  // 3 bit colour padded to the 4 bit ladder, lsb tied low
  assign jamma_video.red   = {core_video.red, 1'b0};
  assign jamma_video.green = {core_video.green, 1'b0};
  assign jamma_video.blue  = {core_video.blue, 1'b0};
  assign jamma_video.hsync = core_video.hsync;
  assign jamma_video.vsync = core_video.vsync;

  assign audio_l = core_audio_l;
  assign audio_r = core_audio_r;
  assign jaudio  = core_audio_l;  // cabinet amp is mono, left channel

endmodule

//--- logic/reboot_requester.sv
`timescale 1ns/10ps

module reboot_requester (
  input  logic pclk,
  input  logic pll_lckd,
  input  logic master_reset,  // keyboard pulse
  input  logic service,       // cabinet service switch, active low
  output logic reboot
);

  localparam int quiet_bits = $clog2(board_pkg::reboot_quiet_cycles) + 1;

  logic                  request;
  logic                  req_q;      // request seen last cycle
  logic                  armed;
  logic [quiet_bits-1:0] quiet_cnt;  // cycles with no request
  logic                  reboot_q;

  assign request = master_reset | ~service;

  always_ff @(posedge pclk or negedge pll_lckd) begin
    if (!pll_lckd) begin
      req_q     <= 1'b0;
      armed     <= 1'b0;             // arms after the first quiet window
      quiet_cnt <= '0;
      reboot_q  <= 1'b0;
    end else begin
      req_q    <= request;
      reboot_q <= request & armed;   // one strobe, then disarm
      if (request && armed) begin
        armed <= 1'b0;
      end
      if (req_q || request) begin
        quiet_cnt <= '0;
      end else if (quiet_cnt == quiet_bits'(board_pkg::reboot_quiet_cycles - 1)) begin
        armed     <= 1'b1;           // 16th quiet cycle
        quiet_cnt <= quiet_cnt + 1'b1;
      end else if (quiet_cnt != quiet_bits'(board_pkg::reboot_quiet_cycles)) begin
        quiet_cnt <= quiet_cnt + 1'b1;
      end
    end
  end

  assign reboot = reboot_q;

  ////////////////////////////////////////
  // multiboot expects a single strobe
  a_reboot_single : assert property (
    @(posedge pclk) disable iff (!pll_lckd)
    reboot |=> !reboot
  ) else $error("reboot high on consecutive cycles");

endmodule

//--- logic/ps2_key_scanner.sv
`timescale 1ns/10ps

module ps2_key_scanner (
  input  logic                  pclk,
  input  logic                  pll_lckd,
  input  logic                  ps2_clk,
  input  logic                  ps2_data,
  output board_pkg::key_flags_t key_flags
);

  localparam int idle_bits = $clog2(board_pkg::ps2_timeout_cycles) + 1;

  logic [2:0]           clk_sync;      // two sync stages plus edge history
  logic [1:0]           data_sync;
  logic                 clk_fall;
  logic                 data_bit;      // synchronized data line
  logic [3:0]           bit_cnt;       // 0 idle, 1..8 data, 9 parity, 10 stop
  logic [idle_bits-1:0] idle_cnt;
  logic [7:0]           shift_reg;     // lsb first
  logic                 parity_bit;
  logic                 frame_ok;      // good frame completes this cycle
  logic                 break_pending; // last code was the release prefix
  logic                 reset_key_q;
  logic                 scanlines_q;
  logic                 led_on_q;
  logic                 master_q;

  ////////////////////////////////////////
  // input synchronizers
  ////////////////////////////////////////
  always_ff @(posedge pclk or negedge pll_lckd) begin
    if (!pll_lckd) begin
      clk_sync  <= '1;                       // bus idles high
      data_sync <= '1;
    end else begin
      clk_sync  <= {clk_sync[1:0], ps2_clk};
      data_sync <= {data_sync[0], ps2_data};
    end
  end

  assign clk_fall = clk_sync[2] & ~clk_sync[1];  // device drives data before falling
  assign data_bit = data_sync[1];

  ////////////////////////////////////////
  // frame receiver
  ////////////////////////////////////////
  always_ff @(posedge pclk or negedge pll_lckd) begin
    if (!pll_lckd) begin
      bit_cnt  <= '0;
      idle_cnt <= '0;
    end else if (clk_fall) begin
      idle_cnt <= '0;
      if (bit_cnt == 4'd0) begin
        if (!data_bit) begin
          bit_cnt <= 4'd1;                   // start bit seen
        end
      end else if (bit_cnt == 4'd10) begin
        bit_cnt <= 4'd0;                     // stop slot, good or bad
      end else begin
        bit_cnt <= bit_cnt + 4'd1;
      end
    end else if (bit_cnt != 4'd0) begin
      // stalled mid-frame, give up and wait for a fresh start bit
      if (idle_cnt == idle_bits'(board_pkg::ps2_timeout_cycles)) begin
        bit_cnt  <= '0;
        idle_cnt <= '0;
      end else begin
        idle_cnt <= idle_cnt + 1'b1;
      end
    end
  end

  // payload path
  always_ff @(posedge pclk) begin
    if (clk_fall && (bit_cnt >= 4'd1) && (bit_cnt <= 4'd8)) begin
      shift_reg <= {data_bit, shift_reg[7:1]};
    end
    if (clk_fall && (bit_cnt == 4'd9)) begin
      parity_bit <= data_bit;
    end
  end

  // odd parity over data plus parity bit, stop must be high
  assign frame_ok = clk_fall && (bit_cnt == 4'd10) && data_bit
                    && (^{shift_reg, parity_bit});

  ////////////////////////////////////////
  // scan code decoder
  ////////////////////////////////////////
  always_ff @(posedge pclk or negedge pll_lckd) begin
    if (!pll_lckd) begin
      break_pending <= 1'b0;
      reset_key_q   <= 1'b0;
      scanlines_q   <= 1'b0;
      led_on_q      <= 1'b0;
      master_q      <= 1'b0;
    end else begin
      master_q <= 1'b0;                      // pulse by default
      if (frame_ok) begin
        if (shift_reg == board_pkg::key_break_code) begin
          break_pending <= 1'b1;
        end else begin
          break_pending <= 1'b0;             // prefix consumed by any other code
          case (shift_reg)
            board_pkg::key_reset_code: begin
              reset_key_q <= ~break_pending; // held while down
            end
            board_pkg::key_scan_code: begin
              if (!break_pending) begin
                scanlines_q <= ~scanlines_q;
              end
            end
            board_pkg::key_led_code: begin
              if (!break_pending) begin
                led_on_q <= ~led_on_q;
              end
            end
            board_pkg::key_master_code: begin
              master_q <= ~break_pending;
            end
            default: ;                       // other keys ignored
          endcase
        end
      end
    end
  end

  assign key_flags.reset_key    = reset_key_q;
  assign key_flags.scanlines    = scanlines_q;
  assign key_flags.led_on       = led_on_q;
  assign key_flags.master_reset = master_q;

  // downstream reboot logic counts pulses
  a_master_single : assert property (
    @(posedge pclk) disable iff (!pll_lckd)
    master_q |=> !master_q
  ) else $error("master_reset longer than one cycle");

endmodule

//--- logic/jamma_joy_sampler.sv
`timescale 1ns/10ps

module jamma_joy_sampler #(
  parameter int joy_type = 1  // 0 local port only, 1 jamma multiplexed bus
) (
  input  logic                                 pclk,
  input  logic                                 pll_lckd,
  input  logic [board_pkg::joy_port_bits-1:0] joystick,   // on-board port, active low
  input  board_pkg::joy_t                      jjoy,       // shared cabinet bus
  output logic                                 jselect,
  output board_pkg::joy_t                      joystick_a,
  output board_pkg::joy_t                      joystick_b
);

  generate
    if (joy_type == 1) begin : g_jamma

      logic            jselect_q;  // player select toward the cabinet
      board_pkg::joy_t joy_a_q;
      board_pkg::joy_t joy_b_q;

      ////////////////////////////////////////
      // player select, toggles every cycle
      ////////////////////////////////////////
      always_ff @(posedge pclk or negedge pll_lckd) begin
        if (!pll_lckd) begin
          jselect_q <= 1'b0;
        end else begin
          jselect_q <= ~jselect_q;
        end
      end

      // bus carries player a while select is low, player b while high
      always_ff @(posedge pclk or negedge pll_lckd) begin
        if (!pll_lckd) begin
          joy_a_q <= '1;                          // nothing pressed
          joy_b_q <= '1;
        end else begin
          if (!jselect_q) begin
            // local port merged into player a, extra buttons only from cabinet
            joy_a_q <= board_pkg::joy_t'(jjoy & {2'b11, joystick});
          end
          if (jselect_q) begin
            joy_b_q <= jjoy;
          end
        end
      end

      assign jselect    = jselect_q;
      assign joystick_a = joy_a_q;
      assign joystick_b = joy_b_q;

      // cabinet mux needs a new select every cycle or one player starves
      a_jselect_toggles : assert property (
        @(posedge pclk) disable iff (!pll_lckd)
        $past(pll_lckd) |-> (jselect != $past(jselect))
      ) else $error("jselect did not toggle");

    end else begin : g_local

      // no cabinet bus, second player parked at idle
      assign jselect    = 1'b0;
      assign joystick_a = board_pkg::joy_t'({2'b11, joystick});
      assign joystick_b = '1;

    end
  endgenerate

endmodule

//--- logic/reset_sequencer.sv
`timescale 1ns/10ps

module reset_sequencer #(
  parameter int reset_hold_bits = 8  // core held in reset for 2**reset_hold_bits cycles
) (
  input  logic pclk,
  input  logic pll_lckd,
  output logic core_reset,
  output logic ena_12,
  output logic ena_6
);

  logic [reset_hold_bits-1:0] delay_count; // free running, also the enable phase
  logic                       core_reset_q;

  ////////////////////////////////////////
  // power-up hold
  ////////////////////////////////////////
  always_ff @(posedge pclk or negedge pll_lckd) begin
    if (!pll_lckd) begin
      delay_count  <= '0;
      core_reset_q <= 1'b1;            // core stays in reset until first wrap
    end else begin
      delay_count <= delay_count + 1'b1;
      if (delay_count == '1) begin
        core_reset_q <= 1'b0;          // released on the wrap edge, never set again
      end
    end
  end

  assign core_reset = core_reset_q;

  ////////////////////////////////////////
  // phase enables
  ////////////////////////////////////////
  // ena_12 on odd counts, half the pclk rate
  assign ena_12 = delay_count[0];

  // ena_6 on count mod 4 == 1, quarter rate and inside an ena_12 slot
  assign ena_6 = delay_count[0] & ~delay_count[1];

  // the 6 enable must always coincide with a 12 enable for the core's dividers
  a_ena_6_in_ena_12 : assert property (
    @(posedge pclk) disable iff (!pll_lckd)
    ena_6 |-> ena_12
  ) else $error("ena_6 high without ena_12");

endmodule

//--- logic/board_pkg.sv
package board_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////
  localparam int core_color_bits     = 3;    // core dac resolution per colour
  localparam int jamma_color_bits    = 4;    // cabinet resistor ladder per colour
  localparam int joy_port_bits       = 6;    // on-board joystick connector
  localparam int ps2_timeout_cycles  = 4096; // mid-frame idle limit in pclk cycles
  localparam int reboot_quiet_cycles = 16;   // quiet time before the reboot rearms

  ////////////////////////////////////////
  // bundles
  ////////////////////////////////////////
  typedef struct packed {
    logic [core_color_bits-1:0] red;
    logic [core_color_bits-1:0] green;
    logic [core_color_bits-1:0] blue;
    logic                       hsync;
    logic                       vsync;
  } core_video_t;

  typedef struct packed {
    logic [jamma_color_bits-1:0] red;
    logic [jamma_color_bits-1:0] green;
    logic [jamma_color_bits-1:0] blue;
    logic                        hsync;
    logic                        vsync;
  } jamma_video_t;

  // one player, all buttons active low
  typedef struct packed {
    logic extra;  // coin side extra, player select on the core
    logic start;
    logic fire2;
    logic fire1;
    logic right;
    logic left;
    logic down;
    logic up;
  } joy_t;

  typedef struct packed {
    logic reset_key;    // held level
    logic scanlines;    // toggle
    logic led_on;       // toggle
    logic master_reset; // single cycle
  } key_flags_t;

  // ps/2 set 2 scan codes
  localparam logic [7:0] key_reset_code  = 8'h76; // esc
  localparam logic [7:0] key_scan_code   = 8'h06; // f2
  localparam logic [7:0] key_led_code    = 8'h83; // f7
  localparam logic [7:0] key_master_code = 8'h07; // f12
  localparam logic [7:0] key_break_code  = 8'hf0; // release prefix

endpackage
